/* verilog/alut_pkg.sv */
// alut package: widths, depth, credits, opcode/status/state enums, command, result and entry structs
package alut_pkg;

   // --------------------
   // sizes and credits
   // --------------------
   localparam int alut_dw     = 83;    // table entry width
   localparam int alut_depth  = 256;   // table entries
   localparam int alut_aw     = 8;     // table index width
   localparam int cmd_credits = 2;     // command queue depth, power of two
   localparam int res_credits = 4;     // result credits after reset

   // plain vectors with a meaning
   typedef logic [47:0]        mac_t;     // mac address
   typedef logic [2:0]         port_t;    // switch port
   typedef logic [30:0]        stamp_t;   // epoch stamp
   typedef logic [alut_aw-1:0] hash_t;    // table index
   typedef logic [alut_aw:0]   count_t;   // removal count, up to a full table

   // --------------------
   // encodings
   // --------------------
   typedef enum logic [1:0] {
      op_learn  = 2'd0,
      op_lookup = 2'd1,
      op_age    = 2'd2
   } alut_op_e;

   // six codes so three bits
   typedef enum logic [2:0] {
      st_new     = 3'd0,   // learn into empty entry
      st_update  = 3'd1,   // learn of a known mac
      st_replace = 3'd2,   // learn over a different mac
      st_hit     = 3'd3,
      st_miss    = 3'd4,
      st_aged    = 3'd5    // sweep done, count valid
   } alut_status_e;

   // address checker fsm
   typedef enum logic [2:0] {a_idle, a_read, a_wait, a_write, a_sweep, a_issue} addr_state_e;

   // age checker fsm
   typedef enum logic [1:0] {g_idle, g_read, g_eval, g_done} age_state_e;

   // --------------------
   // bundles
   // --------------------
   typedef struct packed {
      logic   valid;
      mac_t   mac;
      port_t  port;
      stamp_t stamp;     // epoch at learn time
   } alut_entry_t;

   typedef struct packed {
      alut_op_e op;
      mac_t     mac;
      port_t    port;
      stamp_t   threshold;   // age only
   } alut_cmd_t;

   typedef struct packed {
      alut_op_e     op;
      alut_status_e status;
      port_t        port;
      count_t       count;   // age only
   } alut_res_t;

endpackage

/* verilog/alut_mem.sv */
// dual-port table ram, one read-or-write port for the address checker and one for the age checker
`timescale 1ns/1ns

module alut_mem
(
   input  logic                  pclk20,
   input  alut_pkg::hash_t       mem_addr_add,         // address checker index
   input  logic                  mem_write_add,        // high = write
   input  alut_pkg::alut_entry_t mem_write_data_add,
   input  alut_pkg::hash_t       mem_addr_age,         // age checker index
   input  logic                  mem_write_age,        // high = write
   input  alut_pkg::alut_entry_t mem_write_data_age,
   output alut_pkg::alut_entry_t mem_read_data_add,    // registered read
   output alut_pkg::alut_entry_t mem_read_data_age     // registered read
);

   logic [alut_pkg::alut_dw-1:0] mem_core [alut_pkg::alut_depth];   // storage, no reset

   // --------------------
   // both ports, one process
   // --------------------
   always_ff @(posedge pclk20)
   begin
      if (mem_write_add)
         mem_core[mem_addr_add] <= mem_write_data_add;
      else
         mem_read_data_add <= mem_core[mem_addr_add];   // read, data next cycle

      // callers never write the same index together
      if (mem_write_age)
         mem_core[mem_addr_age] <= mem_write_data_age;
      else
         mem_read_data_age <= mem_core[mem_addr_age];
   end

endmodule

/* verilog/alut_addr_checker.sv */
// address checker: command queue, decode, hash, learn and lookup, epoch, credits, result issue
`timescale 1ns/1ns

module alut_addr_checker
(
   input  logic                  pclk20,
   input  logic                  rst_n,
   input  logic                  cmd_valid,
   input  alut_pkg::alut_cmd_t   cmd,
   output logic                  cmd_credit,          // one pulse per pop
   output logic                  res_valid,
   output alut_pkg::alut_res_t   res,
   input  logic                  res_credit,          // one pulse per consumed result
   output alut_pkg::hash_t       mem_addr_add,
   output logic                  mem_write_add,
   output alut_pkg::alut_entry_t mem_write_data_add,
   input  alut_pkg::alut_entry_t mem_read_data_add,
   output logic                  age_start,
   output alut_pkg::stamp_t      age_threshold,
   output alut_pkg::stamp_t      epoch,
   input  logic                  age_done,
   input  alut_pkg::count_t      age_count
);

   alut_pkg::alut_cmd_t                      cmd_q [alut_pkg::cmd_credits];
   logic [$clog2(alut_pkg::cmd_credits)-1:0] q_wr;
   logic [$clog2(alut_pkg::cmd_credits)-1:0] q_rd;
   logic [$clog2(alut_pkg::cmd_credits):0]   q_cnt;      // entries held
   logic [$clog2(alut_pkg::res_credits):0]   res_cnt;    // result credits left
   alut_pkg::addr_state_e                    state;
   alut_pkg::alut_cmd_t                      cur;        // command in flight
   alut_pkg::alut_entry_t                    rd_q;       // entry read at hash
   alut_pkg::alut_entry_t                    wr_entry;
   alut_pkg::alut_res_t                      eval_res;
   alut_pkg::alut_res_t                      res_q;
   alut_pkg::hash_t                          init_idx;
   logic                                     init_busy;  // clear sweep after reset
   logic                                     pop;
   logic                                     issue;
   logic                                     same_mac;

   // xor of the six mac bytes
   function automatic alut_pkg::hash_t mac_hash(input alut_pkg::mac_t m);
      alut_pkg::hash_t h;
      h = '0;
      for (int i = 0; i < 6; i++)
         h = h ^ m[8*i +: 8];
      return h;
   endfunction

   assign pop       = (state == alut_pkg::a_idle) && !init_busy && (q_cnt != '0);
   assign issue     = (state == alut_pkg::a_issue) && (res_cnt != '0);   // stall at zero credits
   assign res_valid = issue;
   assign res       = res_q;

   // --------------------
   // command queue
   // --------------------
   always_ff @(posedge pclk20)
      if (cmd_valid)
         cmd_q[q_wr] <= cmd;   // sender only sends with a credit

   always_ff @(posedge pclk20 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         q_wr  <= '0;
         q_rd  <= '0;
         q_cnt <= '0;
      end
      else
      begin
         if (cmd_valid)
            q_wr <= q_wr + 1'b1;   // wraps, depth is a power of two
         if (pop)
            q_rd <= q_rd + 1'b1;
         if (cmd_valid && !pop)
            q_cnt <= q_cnt + 1'b1;
         else if (!cmd_valid && pop)
            q_cnt <= q_cnt - 1'b1;
      end
   end

   // --------------------
   // control fsm
   // --------------------
   always_ff @(posedge pclk20 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state      <= alut_pkg::a_idle;
         init_busy  <= 1'b1;
         init_idx   <= '0;
         epoch      <= '0;
         res_cnt    <= ($bits(res_cnt))'(alut_pkg::res_credits);
         age_start  <= 1'b0;
         cmd_credit <= 1'b0;
      end
      else
      begin
         age_start  <= 1'b0;
         cmd_credit <= pop;   // slot freed, give credit back
         if (init_busy)
         begin
            init_idx <= init_idx + 1'b1;
            if (init_idx == alut_pkg::hash_t'(alut_pkg::alut_depth - 1))
               init_busy <= 1'b0;
         end
         case (state)
            alut_pkg::a_idle:
               if (pop)
               begin
                  if (cmd_q[q_rd].op == alut_pkg::op_age)
                  begin
                     state     <= alut_pkg::a_sweep;
                     age_start <= 1'b1;   // cur latched on this same edge
                  end
                  else
                     state <= alut_pkg::a_read;   // learn, lookup, unknown as lookup
               end
            alut_pkg::a_read:  state <= alut_pkg::a_wait;
            alut_pkg::a_wait:  state <= alut_pkg::a_write;
            alut_pkg::a_write:
            begin
               if (cur.op == alut_pkg::op_learn)
                  epoch <= epoch + 1'b1;   // time moves once per learn
               state <= alut_pkg::a_issue;
            end
            alut_pkg::a_sweep:
               if (age_done)
                  state <= alut_pkg::a_issue;
            alut_pkg::a_issue:
               if (issue)
                  state <= alut_pkg::a_idle;
            default: state <= alut_pkg::a_idle;
         endcase
         if (res_credit && !issue)
            res_cnt <= res_cnt + 1'b1;
         else if (!res_credit && issue)
            res_cnt <= res_cnt - 1'b1;
      end
   end

   // payload registers
   always_ff @(posedge pclk20)
   begin
      if (pop)
         cur <= cmd_q[q_rd];
      if (state == alut_pkg::a_wait)
         rd_q <= mem_read_data_add;   // ram data valid from this cycle
      if (state == alut_pkg::a_write)
         res_q <= eval_res;
      else if (state == alut_pkg::a_sweep && age_done)
         res_q <= '{op: cur.op, status: alut_pkg::st_aged, port: '0, count: age_count};
   end

   // --------------------
   // learn / lookup evaluation
   // --------------------
   always_comb
   begin
      same_mac = rd_q.valid && (rd_q.mac == cur.mac);
      wr_entry = '{valid: 1'b1, mac: cur.mac, port: cur.port, stamp: epoch};
      eval_res = '{op: cur.op, status: alut_pkg::st_miss, port: '0, count: '0};
      if (cur.op == alut_pkg::op_learn)
      begin
         eval_res.port = cur.port;
         if (!rd_q.valid)
            eval_res.status = alut_pkg::st_new;
         else if (same_mac)
            eval_res.status = alut_pkg::st_update;
         else
            eval_res.status = alut_pkg::st_replace;   // collision, old mac lost
      end
      else if (same_mac)
      begin
         eval_res.status = alut_pkg::st_hit;
         eval_res.port   = rd_q.port;
      end
   end

   // ram port, init sweep owns it until done
   assign mem_addr_add       = init_busy ? init_idx : mac_hash(cur.mac);
   assign mem_write_add      = init_busy ||
                               (state == alut_pkg::a_write && cur.op == alut_pkg::op_learn);
   assign mem_write_data_add = init_busy ? '0 : wr_entry;
   assign age_threshold      = cur.threshold;

endmodule

/* verilog/alut_age_checker.sv */
// age checker: sweep over the table, clearing and counting stale entries through the age port
`timescale 1ns/1ns

module alut_age_checker
(
   input  logic                  pclk20,
   input  logic                  rst_n,
   input  logic                  age_start,          // one-cycle kick
   input  alut_pkg::stamp_t      age_threshold,
   input  alut_pkg::stamp_t      epoch,
   output logic                  age_done,           // one-cycle end of sweep
   output alut_pkg::count_t      age_count,
   output alut_pkg::hash_t       mem_addr_age,
   output logic                  mem_write_age,
   output alut_pkg::alut_entry_t mem_write_data_age,
   input  alut_pkg::alut_entry_t mem_read_data_age
);

   alut_pkg::age_state_e  state;
   alut_pkg::hash_t       idx;       // entry under test
   alut_pkg::stamp_t      thr_q;
   alut_pkg::stamp_t      epoch_q;   // time frozen at start
   alut_pkg::stamp_t      age;
   alut_pkg::alut_entry_t clr_entry;
   logic                  stale;

   // --------------------
   // stale test
   // --------------------
   always_comb
   begin
      age             = epoch_q - mem_read_data_age.stamp;   // wraps mod 2^31
      stale           = mem_read_data_age.valid && (age > thr_q);
      clr_entry       = mem_read_data_age;
      clr_entry.valid = 1'b0;
   end

   assign mem_addr_age       = idx;
   assign mem_write_age      = (state == alut_pkg::g_eval) && stale;
   assign mem_write_data_age = clr_entry;
   assign age_done           = (state == alut_pkg::g_done);

   // --------------------
   // sweep fsm, two cycles per entry
   // --------------------
   always_ff @(posedge pclk20 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= alut_pkg::g_idle;
         idx       <= '0;
         thr_q     <= '0;
         epoch_q   <= '0;
         age_count <= '0;
      end
      else
      begin
         case (state)
            alut_pkg::g_idle:
               if (age_start)
               begin
                  thr_q     <= age_threshold;
                  epoch_q   <= epoch;
                  idx       <= '0;
                  age_count <= '0;
                  state     <= alut_pkg::g_read;
               end
            alut_pkg::g_read: state <= alut_pkg::g_eval;   // read data lands next edge
            alut_pkg::g_eval:
            begin
               if (stale)
                  age_count <= age_count + 1'b1;
               idx <= idx + 1'b1;
               if (idx == alut_pkg::hash_t'(alut_pkg::alut_depth - 1))
                  state <= alut_pkg::g_done;
               else
                  state <= alut_pkg::g_read;
            end
            default: state <= alut_pkg::g_idle;   // g_done lasts one cycle
         endcase
      end
   end

endmodule

/* verilog/alut_top.sv */
// alut top level: address checker, age checker and the shared table ram
`timescale 1ns/1ns

module alut_top
(
   input  logic                pclk20,
   input  logic                rst_n,
   input  logic                cmd_valid,
   input  alut_pkg::alut_cmd_t cmd,
   output logic                cmd_credit,
   output logic                res_valid,
   output alut_pkg::alut_res_t res,
   input  logic                res_credit
);

   // --------------------
   // ram ports
   // --------------------
   alut_pkg::hash_t       mem_addr_add;
   logic                  mem_write_add;
   alut_pkg::alut_entry_t mem_write_data_add;
   alut_pkg::alut_entry_t mem_read_data_add;
   alut_pkg::hash_t       mem_addr_age;
   logic                  mem_write_age;
   alut_pkg::alut_entry_t mem_write_data_age;
   alut_pkg::alut_entry_t mem_read_data_age;

   // sweep handshake
   logic                  age_start;
   logic                  age_done;
   alut_pkg::stamp_t      age_threshold;
   alut_pkg::stamp_t      epoch;
   alut_pkg::count_t      age_count;

   alut_addr_checker u_addr_checker (.*);   // command side, owns the add port

   alut_age_checker u_age_checker (.*);     // sweep side, owns the age port

   alut_mem u_mem (
      .pclk20             (pclk20),
      .mem_addr_add       (mem_addr_add),
      .mem_write_add      (mem_write_add),
      .mem_write_data_add (mem_write_data_add),
      .mem_addr_age       (mem_addr_age),
      .mem_write_age      (mem_write_age),
      .mem_write_data_age (mem_write_data_age),
      .mem_read_data_add  (mem_read_data_add),
      .mem_read_data_age  (mem_read_data_age)
   );

endmodule

/* verification/alut_monitor.sv */
// reference table model, reference function, in-order result check and error counts for the alut
`timescale 1ns/1ns

module alut_monitor
(
   input  logic                pclk20,
   input  logic                rst_n,
   input  logic                cmd_valid,
   input  alut_pkg::alut_cmd_t cmd,
   input  logic                cmd_credit,
   input  logic                res_valid,
   input  alut_pkg::alut_res_t res,
   input  logic                res_credit,
   output int                  n_results,    // results seen so far
   output int                  n_mismatch,   // wrong result values
   output int                  n_proto       // credit and ordering faults
);

   alut_pkg::alut_entry_t ref_tbl [alut_pkg::alut_depth];   // expected table contents
   alut_pkg::stamp_t      ref_epoch;
   alut_pkg::alut_cmd_t   pending [$];    // accepted and not yet answered
   alut_pkg::alut_cmd_t   head;
   alut_pkg::alut_res_t   exp_res;
   int                    cmd_cr;         // sender credits
   int                    res_cr;         // dut result credits
   int                    seen  = 0;
   int                    bad   = 0;
   int                    proto = 0;

   assign n_results  = seen;
   assign n_mismatch = bad;
   assign n_proto    = proto;

   // --------------------
   // reference function
   // --------------------
   function automatic alut_pkg::alut_res_t expected_result(input alut_pkg::alut_cmd_t c);
      alut_pkg::alut_res_t r;
      alut_pkg::hash_t     h;
      alut_pkg::hash_t     k;
      alut_pkg::stamp_t    age;
      h = c.mac[47:40] ^ c.mac[39:32] ^ c.mac[31:24] ^
          c.mac[23:16] ^ c.mac[15:8] ^ c.mac[7:0];   // byte xor index
      r    = '0;
      r.op = c.op;
      case (c.op)
         alut_pkg::op_learn:
         begin
            r.port = c.port;   // learn echoes its own port
            if (!ref_tbl[h].valid)
               r.status = alut_pkg::st_new;
            else if (ref_tbl[h].mac == c.mac)
               r.status = alut_pkg::st_update;
            else
               r.status = alut_pkg::st_replace;
            ref_tbl[h] = '{1'b1, c.mac, c.port, ref_epoch};
            ref_epoch  = ref_epoch + 1'b1;   // one tick per learn
         end
         alut_pkg::op_age:
         begin
            r.status = alut_pkg::st_aged;
            for (int i = 0; i < alut_pkg::alut_depth; i++)
            begin
               k   = alut_pkg::hash_t'(i);
               age = ref_epoch - ref_tbl[k].stamp;   // wraps like the stamp
               if (ref_tbl[k].valid && age > c.threshold)
               begin
                  ref_tbl[k].valid = 1'b0;
                  r.count          = r.count + 1'b1;
               end
            end
         end
         default:
            if (ref_tbl[h].valid && ref_tbl[h].mac == c.mac)
            begin
               r.status = alut_pkg::st_hit;
               r.port   = ref_tbl[h].port;
            end
            else
               r.status = alut_pkg::st_miss;
      endcase
      return r;
   endfunction

   // --------------------
   // compare at mid-cycle
   // --------------------
   always @(negedge pclk20)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < alut_pkg::alut_depth; i++)
            ref_tbl[alut_pkg::hash_t'(i)] = '0;   // dut clears its table after reset
         ref_epoch = '0;
         cmd_cr    = alut_pkg::cmd_credits;
         res_cr    = alut_pkg::res_credits;
         pending.delete();
      end
      else
      begin
         if (cmd_valid)
         begin
            if (cmd_cr == 0 && !cmd_credit)   // a credit back this cycle may be spent
            begin
               $display("ERROR at %0t: command sent without a command credit", $time);
               proto++;
            end
            pending.push_back(cmd);
            cmd_cr--;
         end
         if (cmd_credit)
            cmd_cr++;
         if (cmd_cr > alut_pkg::cmd_credits)
         begin
            $display("ERROR at %0t: command credit returned with the queue already empty", $time);
            proto++;
            cmd_cr = alut_pkg::cmd_credits;
         end
         if (res_valid)
         begin
            if (res_cr == 0)
            begin
               $display("ERROR at %0t: result issued with no result credit left", $time);
               proto++;
            end
            if (pending.size() == 0)
            begin
               $display("ERROR at %0t: result arrived with no pending command", $time);
               proto++;
            end
            else
            begin
               head    = pending.pop_front();
               exp_res = expected_result(head);
               if (res !== exp_res)
               begin
                  $display("CHECK FAILED time=%0t signal=res expected=%h actual=%h (status %0d/%0d)",
                           $time, exp_res, res, exp_res.status, res.status);
                  bad++;
               end
            end
            res_cr--;
            seen++;
         end
         if (res_credit)
            res_cr++;
      end
   end

endmodule

/* verification/alut_tb.sv */
// clock generator and testbench top with stimulus, result credit return and watchdog for the alut
`timescale 1ns/1ns

// --------------------
// clock source
// --------------------
module alut_clk_gen
(
   output logic pclk20
);

   initial
   begin
      pclk20 = 1'b0;
      forever
         #20 pclk20 = ~pclk20;   // 40 ns period
   end

endmodule

module alut_tb;

   localparam int n_directed = 35;   // directed phases with the second reset
   localparam int n_random   = 60;
   localparam int n_cmds     = n_directed + n_random;

   logic                pclk20;
   logic                rst_n;
   logic                cmd_valid;
   alut_pkg::alut_cmd_t cmd;
   logic                cmd_credit;
   logic                res_valid;
   alut_pkg::alut_res_t res;
   logic                res_credit;
   int                  n_results;
   int                  n_mismatch;
   int                  n_proto;
   int                  credits   = 0;        // command credits held
   int                  n_sent    = 0;
   int                  returned  = 0;        // result credits given back
   int                  seed      = 32'ha2d;
   int                  hold_seed = 32'ha2d;  // own stream for the consumer

   alut_clk_gen clk0 (.pclk20(pclk20));

   alut_top dut0 (
      .pclk20     (pclk20),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .cmd_credit (cmd_credit),
      .res_valid  (res_valid),
      .res        (res),
      .res_credit (res_credit)
   );

   alut_monitor mon0 (.*);

   // locally administered station addresses with distinct hashes
   function automatic alut_pkg::mac_t station_mac(input int i);
      return {40'h02_0000_0000, i[7:0]};
   endfunction

   // one clock with inputs moving 2 ns after the edge
   task automatic next_cycle();
      @(posedge pclk20);
      #2;
      cmd_valid = 1'b0;
      if (cmd_credit)
         credits++;
   endtask

   task automatic send_cmd(input alut_pkg::alut_op_e op, input alut_pkg::mac_t mac,
                           input alut_pkg::port_t port, input alut_pkg::stamp_t thr);
      next_cycle();
      while (credits == 0)
         next_cycle();   // wait for a queue slot
      cmd_valid = 1'b1;
      cmd       = '{op, mac, port, thr};
      credits--;
      n_sent++;
   endtask

   // second reset once all results and credits are settled
   task automatic apply_reset();
      while (n_results < n_sent || returned < n_results)
         next_cycle();
      rst_n = 1'b0;
      repeat (8) next_cycle();
      rst_n   = 1'b1;
      credits = alut_pkg::cmd_credits;   // pre-granted again
   endtask

   // --------------------
   // stimulus
   // --------------------
   initial
   begin
      alut_pkg::mac_t     mac;
      alut_pkg::mac_t     coll_a;
      alut_pkg::alut_op_e op;
      int                 r;
      rst_n     = 1'b0;
      cmd_valid = 1'b0;
      cmd       = '0;
      credits   = alut_pkg::cmd_credits;   // pre-granted
      coll_a    = 48'h0a0b_0c0d_0e1f;
      repeat (8) @(posedge pclk20);
      #2 rst_n = 1'b1;

      for (int i = 0; i < 4; i++)   // table empty after clear sweep
      begin
         r = $random(seed);
         send_cmd(alut_pkg::op_lookup, {r[15:0], r ^ 32'h5a5a_0f0f}, '0, '0);
      end
      for (int i = 0; i < 6; i++)
         send_cmd(alut_pkg::op_learn, station_mac(i), alut_pkg::port_t'(i), '0);
      for (int i = 0; i < 6; i++)
         send_cmd(alut_pkg::op_lookup, station_mac(i), '0, '0);
      send_cmd(alut_pkg::op_learn, station_mac(1), 3'd7, '0);   // moved stations
      send_cmd(alut_pkg::op_learn, station_mac(4), 3'd6, '0);
      send_cmd(alut_pkg::op_lookup, station_mac(1), '0, '0);
      send_cmd(alut_pkg::op_lookup, station_mac(4), '0, '0);
      send_cmd(alut_pkg::op_learn, coll_a, 3'd2, '0);
      send_cmd(alut_pkg::op_learn, coll_a ^ 48'h3c3c, 3'd3, '0);   // same byte xor
      send_cmd(alut_pkg::op_lookup, coll_a, '0, '0);
      send_cmd(alut_pkg::op_lookup, coll_a ^ 48'h3c3c, '0, '0);
      send_cmd(alut_pkg::op_age, '0, '0, 31'd3);
      for (int i = 0; i < 6; i++)
         send_cmd(alut_pkg::op_lookup, station_mac(i), '0, '0);
      send_cmd(alut_pkg::op_lookup, coll_a, '0, '0);
      send_cmd(alut_pkg::op_lookup, coll_a ^ 48'h3c3c, '0, '0);

      // survivors of the sweep vanish across a second reset
      apply_reset();
      send_cmd(alut_pkg::op_lookup, station_mac(4), '0, '0);
      send_cmd(alut_pkg::op_lookup, coll_a ^ 48'h3c3c, '0, '0);

      // random mix over a small address pool
      for (int i = 0; i < n_random; i++)
      begin
         r   = $random(seed);
         mac = {32'h001b_2100, 5'd0, r[2:0], 5'd0, r[5:3]};
         if (r[9:6] < 4'd7)
            op = alut_pkg::op_learn;
         else if (r[9:6] < 4'd15)
            op = alut_pkg::op_lookup;
         else
            op = alut_pkg::op_age;   // rare since a sweep is long
         send_cmd(op, mac, r[12:10], alut_pkg::stamp_t'(r[16:13]));
         if (r[18:17] == 2'd0)
            repeat (r[21:19]) next_cycle();
      end

      while (n_results < n_sent)
         next_cycle();
      $display("errors: mismatch=%0d protocol=%0d results=%0d of %0d",
               n_mismatch, n_proto, n_results, n_sent);
      if (n_mismatch == 0 && n_proto == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // result consumer with random holds
   initial
   begin
      int r;
      res_credit = 1'b0;
      forever
      begin
         @(posedge pclk20);
         #2;
         res_credit = 1'b0;
         r = $random(hold_seed);
         if (r[5:0] == 6'd0)
            repeat (24) @(posedge pclk20);   // long hold drains the dut credits
         else if (returned < n_results && r[7:6] != 2'd0)
         begin
            res_credit = 1'b1;
            returned++;
         end
      end
   end

   // watchdog
   initial
   begin
      repeat (n_cmds * 600 + 1000) @(posedge pclk20);
      $display("timeout: only %0d of %0d results arrived", n_results, n_sent);
      $display("errors: mismatch=%0d protocol=%0d timeout=1", n_mismatch, n_proto);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* alut_top.f */
verilog/alut_pkg.sv
verilog/alut_mem.sv
verilog/alut_addr_checker.sv
verilog/alut_age_checker.sv
verilog/alut_top.sv
verification/alut_monitor.sv
verification/alut_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the alut testbench with verilator, then judge the run from its log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --timescale 1ns/1ns \
   --top-module alut_tb -Mdir "$build_dir" -o alut_sim \
   -f alut_top.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$build_dir/alut_sim" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "Simulation finished: PASS" "$log"; then
   echo "run passed"
   exit 0
fi

echo "run failed"
exit 1
